// ==== filelist.f ====
source/soc_pkg.sv
source/isa_pkg.sv
source/mem_bus_if.sv
source/start_ctrl.sv
source/tiny_core.sv
source/bus_rom.sv
source/bus_ram.sv
source/soc_top.sv
testbench/soc_assert.sv
testbench/tb_soc.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the SoC testbench with Verilator.
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_soc -f filelist.f -o sim_tb_soc

./obj_dir/sim_tb_soc 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation reported a failure."
  exit 1
fi
echo "Simulation finished without a failure."

// ==== testbench/tb_soc.sv ====
// SoC program testbench
`timescale 1ns/10ps
module tb_soc;
  import soc_pkg::*;

  localparam int LOCK_CYCLES = 8;
  localparam int RST_CYCLES  = 16;
  localparam int HOLD_CYCLES = 20;
  localparam int N_ROWS      = 9;
  localparam int SEED        = 15288;
  localparam int LIMIT       = N_ROWS * 400 + 1000; // Watchdog cycles.

  logic             clk;
  logic             arst_n;
  logic [CSR_W-1:0] arg;
  logic [CSR_W-1:0] csr_out;
  logic             fetch_started;
  logic             halted;

  logic [CSR_W-1:0] arg_tab   [N_ROWS];
  logic [CSR_W-1:0] exp_tab   [N_ROWS];
  int               abort_tab [N_ROWS]; // Cycles after fetch start, 0 runs through.
  int               checks;
  int               errors;

  soc_top #(
    .LOCK_CYCLES (LOCK_CYCLES)
  ) DUT (
    .clk           (clk),
    .arst_n        (arst_n),
    .arg           (arg),
    .csr_out       (csr_out),
    .fetch_started (fetch_started),
    .halted        (halted)
  );

  always #20 clk = ~clk; // 40 ns period.

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Program result, 3 * arg + 5 in eight bits.
  function automatic logic [CSR_W-1:0] model_result(input logic [CSR_W-1:0] a);
    return CSR_W'((3 * int'(a) + 5) % 256);
  endfunction

  task automatic build_table();
    arg_tab   = '{8'd0, 8'd1, 8'd84, 8'd85, 8'd255, 8'd0, 8'd0, 8'd0, 8'd0};
    abort_tab = '{0, 0, 57, 0, 0, 0, 45, 0, 0}; // Row 2 aborts after the status store.
    for (int i = 5; i < N_ROWS; i++) begin
      arg_tab[i] = CSR_W'($urandom % 256);
    end
    for (int i = 0; i < N_ROWS; i++) begin
      exp_tab[i] = model_result(arg_tab[i]);
    end
  endtask

  task automatic hold_reset();
    @(posedge clk);
    arst_n <= 1'b0;
    repeat (RST_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_value(32'(csr_out), 32'd0, "csr_out in reset");
    check_value(32'(halted), 32'd0, "halted in reset");
    check_value(32'(fetch_started), 32'd0, "fetch_started in reset");
  endtask

  // **************************************************
  // Release and lock delay
  // **************************************************
  task automatic release_and_lock();
    int n;
    n = 0;
    @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    while (fetch_started !== 1'b1) begin
      @(negedge clk);
      n++;
    end
    check_value(32'(n), 32'(LOCK_CYCLES), "fetch_started delay");
  endtask

  task automatic run_row(input int idx);
    int errs_before;
    errs_before = errors;
    @(posedge clk);
    arg <= arg_tab[idx];
    hold_reset();
    if (abort_tab[idx] > 0) begin
      release_and_lock();
      repeat (abort_tab[idx]) @(negedge clk);
      check_value(32'(halted), 32'd0, "halted before the abort");
      @(posedge clk);
      arst_n <= 1'b0; // Reset in mid program.
      @(negedge clk);
      check_value(32'(csr_out), 32'd0, "csr_out after the abort");
      check_value(32'(fetch_started), 32'd0, "fetch_started after the abort");
      hold_reset();
    end
    release_and_lock();
    // Only the final store may touch csr_out.
    while (halted !== 1'b1) begin
      if (csr_out !== '0) begin
        check_value(32'(csr_out), 32'(exp_tab[idx]), "csr_out before halt");
      end
      @(negedge clk);
    end
    check_value(32'(csr_out), 32'(exp_tab[idx]), "csr_out at halt");
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check_value(32'(csr_out), 32'(exp_tab[idx]), "csr_out after halt");
      check_value(32'(halted), 32'd1, "halted after halt");
    end
    $display("test %0d arg=%0d expected=%0d csr_out=%0d %s", idx, arg_tab[idx],
             exp_tab[idx], csr_out, (errors == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
    arg    = '0;
    checks = 0;
    errors = 0;
    void'($urandom(SEED));
    build_table();
    for (int i = 0; i < N_ROWS; i++) begin
      run_row(i);
    end
    $display("done: %0d tests, %0d checks, %0d errors", N_ROWS, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    repeat (LIMIT) @(posedge clk);
    $display("Timeout: halted never came within %0d cycles.", LIMIT);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== testbench/soc_assert.sv ====
// SoC bus and core checks
`timescale 1ns/10ps
module soc_assert (
  input logic                       clk,
  input logic                       arst_n,
  input logic                       instr_valid,
  input logic                       instr_ready,
  input logic [soc_pkg::ADDR_W-1:0] instr_addr,
  input logic                       lsu_valid,
  input logic                       lsu_ready,
  input logic                       lsu_we,
  input logic [soc_pkg::ADDR_W-1:0] lsu_addr,
  input logic [soc_pkg::DATA_W-1:0] lsu_wdata,
  input logic                       halted
);

  // **************************************************
  // Request/ready handshake
  // **************************************************
  instr_hold: assert property (@(posedge clk) disable iff (!arst_n)
    instr_valid && !instr_ready |=> instr_valid && $stable(instr_addr))
    else $error("instr request dropped or changed before ready");

  lsu_hold: assert property (@(posedge clk) disable iff (!arst_n)
    lsu_valid && !lsu_ready |=>
      lsu_valid && $stable(lsu_we) && $stable(lsu_addr) && $stable(lsu_wdata))
    else $error("lsu request dropped or changed before ready");

  instr_ready_valid: assert property (@(posedge clk) disable iff (!arst_n)
    instr_ready |-> instr_valid)
    else $error("instr ready without valid");

  lsu_ready_valid: assert property (@(posedge clk) disable iff (!arst_n)
    lsu_ready |-> lsu_valid)
    else $error("lsu ready without valid");

  // Halt is sticky until reset.
  halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    halted |=> halted)
    else $error("halted fell without a reset");

endmodule

bind soc_top soc_assert u_assert (
  .clk         (clk),
  .arst_n      (arst_n),
  .instr_valid (instr_bus.valid),
  .instr_ready (instr_bus.ready),
  .instr_addr  (instr_bus.addr),
  .lsu_valid   (lsu_bus.valid),
  .lsu_ready   (lsu_bus.ready),
  .lsu_we      (lsu_bus.we),
  .lsu_addr    (lsu_bus.addr),
  .lsu_wdata   (lsu_bus.wdata),
  .halted      (halted)
);

// ==== source/soc_top.sv ====
// Tiny SoC top level
`timescale 1ns/10ps
module soc_top #(
  parameter int                         LOCK_CYCLES = 8,
  parameter int                         MEM_KB      = 4,
  parameter logic [soc_pkg::ADDR_W-1:0] START_ADDR  = soc_pkg::ROM_BASE
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [soc_pkg::CSR_W-1:0] arg,
  output logic [soc_pkg::CSR_W-1:0] csr_out,
  output logic                      fetch_started,
  output logic                      halted
);

  mem_bus_if instr_bus ();  // Core to ROM.
  mem_bus_if lsu_bus ();    // Core to RAM.

  // Lock delay in place of the PLL.
  start_ctrl #(
    .LOCK_CYCLES (LOCK_CYCLES)
  ) u_start_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .start_fetch (fetch_started)
  );

  tiny_core #(
    .START_ADDR  (START_ADDR)
  ) u_core (
    .clk         (clk),
    .arst_n      (arst_n),
    .start_fetch (fetch_started),
    .instr       (instr_bus),
    .lsu         (lsu_bus),
    .halted      (halted)
  );

  bus_rom u_irom (
    .clk    (clk),
    .arst_n (arst_n),
    .bus    (instr_bus)
  );

  bus_ram #(
    .MEM_KB (MEM_KB)
  ) u_dram (
    .clk     (clk),
    .arst_n  (arst_n),
    .bus     (lsu_bus),
    .arg     (arg),
    .csr_out (csr_out)
  );

endmodule

// ==== source/bus_ram.sv ====
// Data RAM slave with status register
`timescale 1ns/10ps
module bus_ram #(
  parameter int MEM_KB = 4
) (
  input  logic                      clk,
  input  logic                      arst_n,
  mem_bus_if.slave                  bus,
  input  logic [soc_pkg::CSR_W-1:0] arg,
  output logic [soc_pkg::CSR_W-1:0] csr_out
);
  import soc_pkg::*;

  localparam int WORDS = MEM_KB * 1024 / (DATA_W / 8);
  localparam int IDX_W = $clog2(WORDS);

  logic [DATA_W-1:0] mem [WORDS];
  logic [ADDR_W-1:0] offset;
  logic [IDX_W-1:0]  word_idx;
  logic              req;
  logic              hit_csr;
  logic              hit_arg;

  assign req      = bus.valid && !bus.ready;
  assign offset   = bus.addr - RAM_BASE;
  assign word_idx = offset[IDX_W+1:2];
  assign hit_csr  = (bus.addr == CSR_ADDR);
  assign hit_arg  = (bus.addr == ARG_ADDR);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bus.ready <= 1'b0;
      csr_out   <= CSR_RST;
    end else begin
      bus.ready <= req;
      if (req && bus.we && hit_csr) begin
        csr_out <= bus.wdata[CSR_W-1:0]; // Low byte only.
      end
    end
  end

  // **************************************************
  // Word array and read mux
  // **************************************************
  always_ff @(posedge clk) begin
    if (req && bus.we && !hit_csr && !hit_arg) begin
      mem[word_idx] <= bus.wdata;
    end
    if (req) begin
      if (hit_arg) begin
        bus.rdata <= DATA_W'(arg);
      end else if (hit_csr) begin
        bus.rdata <= DATA_W'(csr_out);
      end else begin
        bus.rdata <= mem[word_idx]; // Old data on a write.
      end
    end
  end

endmodule

// ==== source/bus_rom.sv ====
// Program ROM slave
`timescale 1ns/10ps
module bus_rom (
  input  logic     clk,
  input  logic     arst_n,
  mem_bus_if.slave bus
);
  import soc_pkg::*;
  import isa_pkg::*;

  localparam int IDX_W = $clog2(PROG_LEN);

  logic [ADDR_W-1:0] offset;
  logic              in_range;
  logic              req;

  assign offset   = bus.addr - ROM_BASE;
  assign in_range = offset[ADDR_W-1:2] < (ADDR_W - 2)'(PROG_LEN);
  assign req      = bus.valid && !bus.ready;

  // **************************************************
  // One wait cycle handshake
  // **************************************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= req; // Single pulse per request.
    end
  end

  // Past the end of the program the core sees HALT.
  always_ff @(posedge clk) begin
    if (req) begin
      bus.rdata <= in_range ? PROGRAM[offset[IDX_W+1:2]] : HALT_INSTR;
    end
  end

endmodule

// ==== source/tiny_core.sv ====
// Tiny multicycle core
`timescale 1ns/10ps
module tiny_core #(
  parameter logic [soc_pkg::ADDR_W-1:0] START_ADDR = soc_pkg::ROM_BASE
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     start_fetch,
  mem_bus_if.master instr,
  mem_bus_if.master lsu,
  output logic     halted
);
  import soc_pkg::*;
  import isa_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_EXEC,
    S_MEM,
    S_HALT
  } state_e;

  state_e              state;
  logic [ADDR_W-1:0]   pc;
  logic [ADDR_W-1:0]   pc_next;
  logic [INSTR_W-1:0]  ir;
  logic [DATA_W-1:0]   regs [4];
  opcode_e             op;
  logic [REG_W-1:0]    rd;
  logic [REG_W-1:0]    rs;
  logic [DATA_W-1:0]   imm_sx;
  logic [ADDR_W-1:0]   mem_addr;

  // **************************************************
  // Decode
  // **************************************************
  assign op       = opcode_e'(ir[INSTR_W-1:OP_LSB]);
  assign rd       = ir[RD_LSB +: REG_W];
  assign rs       = ir[RS_LSB +: REG_W];
  assign imm_sx   = {{(DATA_W - IMM_W){ir[IMM_W-1]}}, ir[IMM_W-1:0]};
  assign mem_addr = RAM_BASE + ADDR_W'(ir[IMM_W-1:0]);

  // Branch target is a word index into the program.
  assign pc_next = (op == OP_BNZ && regs[rs] != '0) ?
                   START_ADDR + ADDR_W'({ir[IMM_W-1:0], 2'b00}) :
                   pc + ADDR_W'(4);

  // Fetch bus only reads.
  assign instr.addr  = pc;
  assign instr.we    = 1'b0;
  assign instr.wdata = '0;

  // **************************************************
  // Control FSM
  // **************************************************
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= S_IDLE;
      pc          <= START_ADDR;
      instr.valid <= 1'b0;
      lsu.valid   <= 1'b0;
      halted      <= 1'b0;
    end else begin
      case (state)
        S_IDLE: if (start_fetch) begin
          instr.valid <= 1'b1;
          state       <= S_FETCH;
        end
        S_FETCH: if (instr.ready) begin
          instr.valid <= 1'b0;
          state       <= S_EXEC;
        end
        S_EXEC: begin
          if (op == OP_HALT) begin
            halted <= 1'b1;
            state  <= S_HALT;
          end else if (op == OP_LW || op == OP_SW) begin
            lsu.valid <= 1'b1;
            state     <= S_MEM;
          end else begin
            pc          <= pc_next; // Unknown opcodes fall through as no-ops.
            instr.valid <= 1'b1;
            state       <= S_FETCH;
          end
        end
        S_MEM: if (lsu.ready) begin
          lsu.valid   <= 1'b0;
          pc          <= pc + ADDR_W'(4);
          instr.valid <= 1'b1;
          state       <= S_FETCH;
        end
        S_HALT: halted <= 1'b1;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Datapath, register file and load/store payload.
  always_ff @(posedge clk) begin
    if (state == S_FETCH && instr.ready) begin
      ir <= instr.rdata;
    end
    if (state == S_EXEC) begin
      case (op)
        OP_LI:   regs[rd] <= imm_sx;
        OP_ADD:  regs[rd] <= regs[rd] + regs[rs];
        OP_ADDI: regs[rd] <= regs[rd] + imm_sx;
        OP_LW, OP_SW: begin
          lsu.addr  <= mem_addr;
          lsu.we    <= (op == OP_SW);
          lsu.wdata <= regs[rs];
        end
        default: ;
      endcase
    end
    if (state == S_MEM && lsu.ready && !lsu.we) begin
      regs[rd] <= lsu.rdata; // Load writeback.
    end
  end

endmodule

// ==== source/start_ctrl.sv ====
// Clock lock delay
`timescale 1ns/10ps
module start_ctrl #(
  parameter int LOCK_CYCLES = 8
) (
  input  logic clk,
  input  logic arst_n,
  output logic start_fetch
);

  localparam int CNT_W = $clog2(LOCK_CYCLES + 1);

  logic [CNT_W-1:0] lock_cnt;

  // Stands in for the PLL lock signal.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lock_cnt    <= '0;
      start_fetch <= 1'b0;
    end else if (!start_fetch) begin
      lock_cnt <= lock_cnt + 1'b1;
      if (lock_cnt == CNT_W'(LOCK_CYCLES - 1)) begin
        start_fetch <= 1'b1; // Sticky until reset.
      end
    end
  end

endmodule

// ==== source/mem_bus_if.sv ====
// Request/ready memory bus
`timescale 1ns/10ps
interface mem_bus_if #(
  parameter int ADDR_W = soc_pkg::ADDR_W,
  parameter int DATA_W = soc_pkg::DATA_W
) ();

  logic              valid;  // Held until ready.
  logic              ready;  // One cycle pulse per transfer.
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;  // Valid with ready.

  modport master (
    output valid, we, addr, wdata,
    input  ready, rdata
  );

  modport slave (
    input  valid, we, addr, wdata,
    output ready, rdata
  );

endinterface

// ==== source/isa_pkg.sv ====
// Tiny core instruction set
package isa_pkg;

  // Field layout, opcode on top and immediate at the bottom.
  localparam int INSTR_W = 32;
  localparam int OP_W    = 4;
  localparam int REG_W   = 2;
  localparam int IMM_W   = 16;
  localparam int OP_LSB  = INSTR_W - OP_W;  // Bit 28.
  localparam int RD_LSB  = OP_LSB - REG_W;  // Bit 26.
  localparam int RS_LSB  = RD_LSB - REG_W;  // Bit 24.

  typedef enum logic [OP_W-1:0] {
    OP_LI   = 4'h1,
    OP_ADD  = 4'h2,
    OP_ADDI = 4'h3,
    OP_LW   = 4'h4,
    OP_SW   = 4'h5,
    OP_BNZ  = 4'h6,
    OP_HALT = 4'hF
  } opcode_e;

  function automatic logic [INSTR_W-1:0] enc(opcode_e op, logic [REG_W-1:0] rd,
                                             logic [REG_W-1:0] rs, logic [IMM_W-1:0] imm);
    return {op, rd, rs, {(RS_LSB - IMM_W){1'b0}}, imm};
  endfunction

  localparam logic [INSTR_W-1:0] HALT_INSTR = enc(OP_HALT, 2'd0, 2'd0, 16'h0000);

  // **************************************************
  // Fixed program, csr = 3 * arg + 5
  // **************************************************
  localparam int PROG_LEN = 11;
  localparam int LOOP_PC  = 3;  // Word index of the loop body.

  localparam logic [INSTR_W-1:0] PROGRAM [PROG_LEN] = '{
    enc(OP_LW,   2'd1, 2'd0, IMM_W'(soc_pkg::ARG_ADDR)),
    enc(OP_LI,   2'd2, 2'd0, 16'd0),
    enc(OP_LI,   2'd3, 2'd0, 16'd3),
    enc(OP_ADD,  2'd2, 2'd1, 16'd0),     // r2 += arg.
    enc(OP_ADDI, 2'd3, 2'd0, 16'hFFFF),  // Loop count down.
    enc(OP_BNZ,  2'd0, 2'd3, IMM_W'(LOOP_PC)),
    enc(OP_ADDI, 2'd2, 2'd0, 16'd5),
    enc(OP_SW,   2'd0, 2'd2, IMM_W'(soc_pkg::SCRATCH_ADDR)),
    enc(OP_LW,   2'd0, 2'd0, IMM_W'(soc_pkg::SCRATCH_ADDR)),
    enc(OP_SW,   2'd0, 2'd0, IMM_W'(soc_pkg::CSR_ADDR)),
    HALT_INSTR
  };

endpackage

// ==== source/soc_pkg.sv ====
// System bus and memory map
package soc_pkg;

  // Bus widths.
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int CSR_W  = 8;   // Status and argument registers.

  // **************************************************
  // Memory map
  // **************************************************
  localparam logic [ADDR_W-1:0] ROM_BASE     = 32'h8000_0000; // Also the boot address.
  localparam logic [ADDR_W-1:0] RAM_BASE     = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] CSR_ADDR     = 32'h0000_1000; // Status output.
  localparam logic [ADDR_W-1:0] ARG_ADDR     = 32'h0000_1004; // Argument input.
  localparam logic [ADDR_W-1:0] SCRATCH_ADDR = 32'h0000_0010;

  // Reset values.
  localparam logic [CSR_W-1:0] CSR_RST = 8'h00;

endpackage
